//--- pad_ctrl_macros.svh
`ifndef PAD_CTRL_MACROS_SVH
`define PAD_CTRL_MACROS_SVH

////////////////////////////////////////
// Pad frame size
////////////////////////////////////////

`define PAD_N_PADS 10
`define PAD_CFG_W  6

////////////////////////////////////////
// Wishbone bus widths
////////////////////////////////////////

`define PAD_WB_AW 4
`define PAD_WB_DW 32

// Field positions inside one pad word
`define PAD_FLD_SEL_LSB  0
`define PAD_FLD_DCFG_LSB 8
`define PAD_FLD_GCFG_LSB 16

`endif

//--- pad_ctrl_pkg.sv
`include "pad_ctrl_macros.svh"

package pad_ctrl_pkg;

   ////////////////////////////////////////
   // Data types
   ////////////////////////////////////////

   // Drive strength, pull and similar pad settings
   typedef logic [`PAD_CFG_W-1:0]  pad_cfg_t;

   typedef logic [`PAD_WB_AW-1:0]  wb_addr_t;
   typedef logic [`PAD_WB_DW-1:0]  wb_data_t;

   // One bit per pad
   typedef logic [`PAD_N_PADS-1:0] pad_vec_t;

   // Function select of a pad
   typedef enum logic [1:0] {
      PAD_FUNC_PERIPH = 2'd0,
      PAD_FUNC_GPIO   = 2'd1,
      PAD_FUNC_ALT    = 2'd2,
      PAD_FUNC_OFF    = 2'd3
   } pad_func_e;

   ////////////////////////////////////////
   // Pad indices
   ////////////////////////////////////////

   localparam int unsigned PAD_SPIM_SDIO0 = 0;
   localparam int unsigned PAD_SPIM_SDIO1 = 1;
   localparam int unsigned PAD_SPIM_SDIO2 = 2;
   localparam int unsigned PAD_SPIM_SDIO3 = 3;
   localparam int unsigned PAD_SPIM_CSN0  = 4;
   localparam int unsigned PAD_SPIM_SCK   = 5;
   localparam int unsigned PAD_UART_RX    = 6;
   localparam int unsigned PAD_UART_TX    = 7;
   localparam int unsigned PAD_I2C0_SDA   = 8;
   localparam int unsigned PAD_I2C0_SCL   = 9;

endpackage

//--- pad_lane_if.sv
`timescale 1ns/1ps

interface pad_lane_if;

   // Register state of the pad
   pad_ctrl_pkg::pad_func_e sel;
   pad_ctrl_pkg::pad_cfg_t  cfg_dflt;
   pad_ctrl_pkg::pad_cfg_t  cfg_gpio;

   // Candidates for the pad driver
   logic                    func_out;
   logic                    func_oe;
   logic                    alt_out;
   logic                    alt_oe;
   logic                    gpio_out;
   logic                    gpio_oe;

   // Towards the pad cell
   logic                    pad_out;
   logic                    pad_oe;
   pad_ctrl_pkg::pad_cfg_t  pad_cfg;

   modport regs (
      output sel, cfg_dflt, cfg_gpio
   );

   modport lane (
      input  sel, cfg_dflt, cfg_gpio,
      input  func_out, func_oe, alt_out, alt_oe, gpio_out, gpio_oe,
      output pad_out, pad_oe, pad_cfg
   );

   modport router (
      input sel
   );

endinterface

//--- pad_ctrl_regs.sv
`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_ctrl_regs (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   wb_cyc_i,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   input  pad_ctrl_pkg::wb_addr_t wb_adr_i,
   input  pad_ctrl_pkg::wb_data_t wb_dat_i,
   output pad_ctrl_pkg::wb_data_t wb_dat_o,
   output logic                   wb_ack_o,
   pad_lane_if.regs               lanes [`PAD_N_PADS]
);

   import pad_ctrl_pkg::*;

   localparam int unsigned sel_w = $bits(pad_func_e);

   pad_func_e sel_q  [`PAD_N_PADS];
   pad_cfg_t  dcfg_q [`PAD_N_PADS];
   pad_cfg_t  gcfg_q [`PAD_N_PADS];

   logic      ack_q;
   logic      req;
   logic      wr_en;
   wb_data_t  rd_word;
   wb_data_t  rdata_q;

   // New request, one ack per request
   assign req   = wb_cyc_i & wb_stb_i & ~ack_q;
   assign wr_en = req & wb_we_i;

   ////////////////////////////////////////
   // Register file
   ////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         for (int k = 0; k < `PAD_N_PADS; k++) begin
            sel_q[k]  <= PAD_FUNC_PERIPH;
            dcfg_q[k] <= '0;
            gcfg_q[k] <= '0;
         end
      end else begin
         ack_q <= req;
         // Words above the last pad are not decoded
         for (int k = 0; k < `PAD_N_PADS; k++) begin
            if (wr_en && (wb_adr_i == wb_addr_t'(k))) begin
               sel_q[k]  <= pad_func_e'(wb_dat_i[`PAD_FLD_SEL_LSB +: sel_w]);
               dcfg_q[k] <= wb_dat_i[`PAD_FLD_DCFG_LSB +: `PAD_CFG_W];
               gcfg_q[k] <= wb_dat_i[`PAD_FLD_GCFG_LSB +: `PAD_CFG_W];
            end
         end
      end
   end

   ////////////////////////////////////////
   // Read path
   ////////////////////////////////////////

   always_comb begin
      rd_word = '0;
      for (int k = 0; k < `PAD_N_PADS; k++) begin
         if (wb_adr_i == wb_addr_t'(k)) begin
            rd_word[`PAD_FLD_SEL_LSB +: sel_w]       = sel_q[k];
            rd_word[`PAD_FLD_DCFG_LSB +: `PAD_CFG_W] = dcfg_q[k];
            rd_word[`PAD_FLD_GCFG_LSB +: `PAD_CFG_W] = gcfg_q[k];
         end
      end
   end

   // Captured with the request, shown during ack
   always_ff @(posedge clk_i) begin
      if (req && !wb_we_i) begin
         rdata_q <= rd_word;
      end
   end

   assign wb_dat_o = rdata_q;
   assign wb_ack_o = ack_q;

   // Register outputs towards the lanes
   for (genvar g = 0; g < `PAD_N_PADS; g++) begin : g_lane
      assign lanes[g].sel      = sel_q[g];
      assign lanes[g].cfg_dflt = dcfg_q[g];
      assign lanes[g].cfg_gpio = gcfg_q[g];
   end

   // Single cycle ack pulse
   ack_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wb_ack_o |=> !wb_ack_o);

   // No ack outside a live bus cycle
   ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

//--- pad_lane_mux.sv
`timescale 1ns/1ps

module pad_lane_mux (
   pad_lane_if.lane lane
);

   import pad_ctrl_pkg::*;

   ////////////////////////////////////////
   // Driver select
   ////////////////////////////////////////

   always_comb begin
      case (lane.sel)
         PAD_FUNC_PERIPH: begin
            lane.pad_out = lane.func_out;
            lane.pad_oe  = lane.func_oe;
         end
         PAD_FUNC_GPIO: begin
            lane.pad_out = lane.gpio_out;
            lane.pad_oe  = lane.gpio_oe;
         end
         PAD_FUNC_ALT: begin
            lane.pad_out = lane.alt_out;
            lane.pad_oe  = lane.alt_oe;
         end
         default: begin
            // Pad parked, driver off
            lane.pad_out = 1'b0;
            lane.pad_oe  = 1'b0;
         end
      endcase
   end

   // GPIO word only while the pad is a GPIO
   assign lane.pad_cfg = (lane.sel == PAD_FUNC_GPIO) ? lane.cfg_gpio : lane.cfg_dflt;

endmodule

//--- pad_in_router.sv
`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_in_router (
   input  pad_ctrl_pkg::pad_vec_t pad_in_i,
   pad_lane_if.router             lanes [`PAD_N_PADS],
   output logic [3:0]             spi_sdi_o,
   output logic                   uart_rx_o,
   output logic [1:0]             i2c_sda_in_o,
   output logic [1:0]             i2c_scl_in_o,
   output pad_ctrl_pkg::pad_vec_t gpio_in_o
);

   import pad_ctrl_pkg::*;

   pad_vec_t is_periph;
   pad_vec_t is_gpio;
   pad_vec_t is_alt;

   // Decoded mode per pad
   for (genvar g = 0; g < `PAD_N_PADS; g++) begin : g_mode
      assign is_periph[g] = (lanes[g].sel == PAD_FUNC_PERIPH);
      assign is_gpio[g]   = (lanes[g].sel == PAD_FUNC_GPIO);
      assign is_alt[g]    = (lanes[g].sel == PAD_FUNC_ALT);
   end

   ////////////////////////////////////////
   // Peripheral inputs
   ////////////////////////////////////////

   // SPI data lines idle low
   assign spi_sdi_o = pad_in_i[PAD_SPIM_SDIO3:PAD_SPIM_SDIO0]
                    & is_periph[PAD_SPIM_SDIO3:PAD_SPIM_SDIO0];

   // UART line idles high
   assign uart_rx_o = is_periph[PAD_UART_RX] ? pad_in_i[PAD_UART_RX] : 1'b1;

   // I2C0 on its own pads
   assign i2c_sda_in_o[0] = is_periph[PAD_I2C0_SDA] ? pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign i2c_scl_in_o[0] = is_periph[PAD_I2C0_SCL] ? pad_in_i[PAD_I2C0_SCL] : 1'b1;

   // I2C1 as alternate, SPI pads win over UART pads
   always_comb begin
      if (is_alt[PAD_SPIM_SDIO2]) begin
         i2c_sda_in_o[1] = pad_in_i[PAD_SPIM_SDIO2];
      end else if (is_alt[PAD_UART_RX]) begin
         i2c_sda_in_o[1] = pad_in_i[PAD_UART_RX];
      end else begin
         i2c_sda_in_o[1] = 1'b1;
      end

      if (is_alt[PAD_SPIM_SDIO3]) begin
         i2c_scl_in_o[1] = pad_in_i[PAD_SPIM_SDIO3];
      end else if (is_alt[PAD_UART_TX]) begin
         i2c_scl_in_o[1] = pad_in_i[PAD_UART_TX];
      end else begin
         i2c_scl_in_o[1] = 1'b1;
      end
   end

   ////////////////////////////////////////
   // GPIO inputs
   ////////////////////////////////////////

   always_comb begin
      gpio_in_o = pad_in_i & is_gpio;
   end

endmodule

//--- pad_ctrl_top.sv
`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module pad_ctrl_top (
   input  logic                   clk_i,
   input  logic                   arst_n_i,

   // Wishbone slave
   input  logic                   wb_cyc_i,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   input  pad_ctrl_pkg::wb_addr_t wb_adr_i,
   input  pad_ctrl_pkg::wb_data_t wb_dat_i,
   output pad_ctrl_pkg::wb_data_t wb_dat_o,
   output logic                   wb_ack_o,

   // SPI master
   input  logic                   spi_sck_i,
   input  logic                   spi_csn_i,
   input  logic [3:0]             spi_sdo_i,
   input  logic [3:0]             spi_oe_i,
   output logic [3:0]             spi_sdi_o,

   // UART
   input  logic                   uart_tx_i,
   output logic                   uart_rx_o,

   // I2C masters
   input  logic [1:0]             i2c_sda_out_i,
   input  logic [1:0]             i2c_sda_oe_i,
   input  logic [1:0]             i2c_scl_out_i,
   input  logic [1:0]             i2c_scl_oe_i,
   output logic [1:0]             i2c_sda_in_o,
   output logic [1:0]             i2c_scl_in_o,

   // Timers
   input  logic [3:0]             timer_i,

   // GPIO
   input  pad_ctrl_pkg::pad_vec_t gpio_out_i,
   input  pad_ctrl_pkg::pad_vec_t gpio_dir_i,
   output pad_ctrl_pkg::pad_vec_t gpio_in_o,

   // Pad frame
   input  pad_ctrl_pkg::pad_vec_t pad_in_i,
   output pad_ctrl_pkg::pad_vec_t pad_out_o,
   output pad_ctrl_pkg::pad_vec_t pad_oe_o,
   output pad_ctrl_pkg::pad_cfg_t pad_cfg_o [`PAD_N_PADS]
);

   import pad_ctrl_pkg::*;

   pad_vec_t func_out;
   pad_vec_t func_oe;
   pad_vec_t alt_out;
   pad_vec_t alt_oe;

   pad_lane_if lanes [`PAD_N_PADS] ();

   ////////////////////////////////////////
   // Peripheral function per pad
   ////////////////////////////////////////

   assign func_out[PAD_SPIM_SDIO3:PAD_SPIM_SDIO0] = spi_sdo_i;
   assign func_oe[PAD_SPIM_SDIO3:PAD_SPIM_SDIO0]  = spi_oe_i;
   assign func_out[PAD_SPIM_CSN0] = spi_csn_i;
   assign func_oe[PAD_SPIM_CSN0]  = 1'b1;
   assign func_out[PAD_SPIM_SCK]  = spi_sck_i;
   assign func_oe[PAD_SPIM_SCK]   = 1'b1;
   // Input only pad
   assign func_out[PAD_UART_RX]   = 1'b0;
   assign func_oe[PAD_UART_RX]    = 1'b0;
   assign func_out[PAD_UART_TX]   = uart_tx_i;
   assign func_oe[PAD_UART_TX]    = 1'b1;
   assign func_out[PAD_I2C0_SDA]  = i2c_sda_out_i[0];
   assign func_oe[PAD_I2C0_SDA]   = i2c_sda_oe_i[0];
   assign func_out[PAD_I2C0_SCL]  = i2c_scl_out_i[0];
   assign func_oe[PAD_I2C0_SCL]   = i2c_scl_oe_i[0];

   ////////////////////////////////////////
   // Alternate function per pad
   ////////////////////////////////////////

   assign alt_out[PAD_SPIM_SDIO0] = timer_i[0];
   assign alt_oe[PAD_SPIM_SDIO0]  = 1'b1;
   assign alt_out[PAD_SPIM_SDIO1] = timer_i[1];
   assign alt_oe[PAD_SPIM_SDIO1]  = 1'b1;
   assign alt_out[PAD_SPIM_SDIO2] = i2c_sda_out_i[1];
   assign alt_oe[PAD_SPIM_SDIO2]  = i2c_sda_oe_i[1];
   assign alt_out[PAD_SPIM_SDIO3] = i2c_scl_out_i[1];
   assign alt_oe[PAD_SPIM_SDIO3]  = i2c_scl_oe_i[1];
   assign alt_out[PAD_SPIM_CSN0]  = timer_i[2];
   assign alt_oe[PAD_SPIM_CSN0]   = 1'b1;
   assign alt_out[PAD_SPIM_SCK]   = timer_i[3];
   assign alt_oe[PAD_SPIM_SCK]    = 1'b1;
   // Second placement of I2C1
   assign alt_out[PAD_UART_RX]    = i2c_sda_out_i[1];
   assign alt_oe[PAD_UART_RX]     = i2c_sda_oe_i[1];
   assign alt_out[PAD_UART_TX]    = i2c_scl_out_i[1];
   assign alt_oe[PAD_UART_TX]     = i2c_scl_oe_i[1];
   // No alternate on the I2C0 pads
   assign alt_out[PAD_I2C0_SDA]   = 1'b0;
   assign alt_oe[PAD_I2C0_SDA]    = 1'b0;
   assign alt_out[PAD_I2C0_SCL]   = 1'b0;
   assign alt_oe[PAD_I2C0_SCL]    = 1'b0;

   ////////////////////////////////////////
   // Instances
   ////////////////////////////////////////

   pad_ctrl_regs i_pad_ctrl_regs (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .lanes    (lanes)
   );

   for (genvar g = 0; g < `PAD_N_PADS; g++) begin : g_pad
      assign lanes[g].func_out = func_out[g];
      assign lanes[g].func_oe  = func_oe[g];
      assign lanes[g].alt_out  = alt_out[g];
      assign lanes[g].alt_oe   = alt_oe[g];
      assign lanes[g].gpio_out = gpio_out_i[g];
      assign lanes[g].gpio_oe  = gpio_dir_i[g];

      pad_lane_mux i_pad_lane_mux (
         .lane (lanes[g])
      );

      assign pad_out_o[g] = lanes[g].pad_out;
      assign pad_oe_o[g]  = lanes[g].pad_oe;
      assign pad_cfg_o[g] = lanes[g].pad_cfg;
   end

   pad_in_router i_pad_in_router (
      .pad_in_i     (pad_in_i),
      .lanes        (lanes),
      .spi_sdi_o    (spi_sdi_o),
      .uart_rx_o    (uart_rx_o),
      .i2c_sda_in_o (i2c_sda_in_o),
      .i2c_scl_in_o (i2c_scl_in_o),
      .gpio_in_o    (gpio_in_o)
   );

endmodule

//--- tb_pad_ctrl.sv
`timescale 1ns/1ps

`include "pad_ctrl_macros.svh"

module tb_pad_ctrl;

   import pad_ctrl_pkg::*;

   localparam int          n_pads      = `PAD_N_PADS;
   localparam int          t_period    = 40;
   localparam int          t_drive     = 2;
   localparam int unsigned wb_wait_max = 16;
   localparam logic [31:0] lcg_seed    = 32'h7b9d_c2a5;

   logic       clk;
   logic       arst_n;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   wb_addr_t   wb_adr;
   wb_data_t   wb_dat_w;
   wb_data_t   wb_dat_r;
   logic       wb_ack;
   logic       spi_sck;
   logic       spi_csn;
   logic [3:0] spi_sdo;
   logic [3:0] spi_oe;
   logic [3:0] spi_sdi;
   logic       uart_tx;
   logic       uart_rx;
   logic [1:0] i2c_sda_out;
   logic [1:0] i2c_sda_oe;
   logic [1:0] i2c_scl_out;
   logic [1:0] i2c_scl_oe;
   logic [1:0] i2c_sda_in;
   logic [1:0] i2c_scl_in;
   logic [3:0] timer;
   pad_vec_t   gpio_out;
   pad_vec_t   gpio_dir;
   pad_vec_t   gpio_in;
   pad_vec_t   pad_in;
   pad_vec_t   pad_out;
   pad_vec_t   pad_oe;
   pad_cfg_t   pad_cfg [`PAD_N_PADS];

   // Shadow of the register block
   pad_func_e  sh_sel  [`PAD_N_PADS];
   pad_cfg_t   sh_dcfg [`PAD_N_PADS];
   pad_cfg_t   sh_gcfg [`PAD_N_PADS];

   pad_vec_t   exp_out;
   pad_vec_t   exp_oe;
   logic [`PAD_N_PADS*`PAD_CFG_W-1:0] exp_cfg;
   logic [`PAD_N_PADS*`PAD_CFG_W-1:0] act_cfg;
   logic [18:0] exp_rt;

   logic [31:0] lcg_state;
   string       cur_test;
   int          err_cnt;
   int          err_at_start;
   int          test_cnt;
   int          bad_tests;

   pad_ctrl_top i_pad_ctrl_top (
      .clk_i (clk), .arst_n_i (arst_n),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
      .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
      .spi_sck_i (spi_sck), .spi_csn_i (spi_csn), .spi_sdo_i (spi_sdo),
      .spi_oe_i (spi_oe), .spi_sdi_o (spi_sdi),
      .uart_tx_i (uart_tx), .uart_rx_o (uart_rx),
      .i2c_sda_out_i (i2c_sda_out), .i2c_sda_oe_i (i2c_sda_oe),
      .i2c_scl_out_i (i2c_scl_out), .i2c_scl_oe_i (i2c_scl_oe),
      .i2c_sda_in_o (i2c_sda_in), .i2c_scl_in_o (i2c_scl_in),
      .timer_i (timer),
      .gpio_out_i (gpio_out), .gpio_dir_i (gpio_dir), .gpio_in_o (gpio_in),
      .pad_in_i (pad_in), .pad_out_o (pad_out), .pad_oe_o (pad_oe), .pad_cfg_o (pad_cfg)
   );

   initial begin
      clk = 1'b0;
      forever #(t_period / 2) clk = ~clk;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // {out, oe} of one pad from the function table
   function automatic logic [1:0] exp_drive(int k);
      logic [1:0] periph;
      logic [1:0] alt;
      case (k)
         0, 1, 2, 3: periph = {spi_sdo[k], spi_oe[k]};
         4: periph = {spi_csn, 1'b1};
         5: periph = {spi_sck, 1'b1};
         7: periph = {uart_tx, 1'b1};
         8: periph = {i2c_sda_out[0], i2c_sda_oe[0]};
         9: periph = {i2c_scl_out[0], i2c_scl_oe[0]};
         default: periph = 2'b00;
      endcase
      case (k)
         0, 1: alt = {timer[k], 1'b1};
         4, 5: alt = {timer[k-2], 1'b1};
         2, 6: alt = {i2c_sda_out[1], i2c_sda_oe[1]};
         3, 7: alt = {i2c_scl_out[1], i2c_scl_oe[1]};
         default: alt = 2'b00;
      endcase
      case (sh_sel[k])
         PAD_FUNC_PERIPH: return periph;
         PAD_FUNC_GPIO: return {gpio_out[k], gpio_dir[k]};
         PAD_FUNC_ALT: return alt;
         default: return 2'b00;
      endcase
   endfunction

   // {spi_sdi, uart_rx, i2c_sda_in, i2c_scl_in, gpio_in}
   function automatic logic [18:0] exp_route();
      logic [3:0] sdi;
      logic       rx;
      logic [1:0] sda;
      logic [1:0] scl;
      pad_vec_t   gin;
      for (int k = 0; k < 4; k++) begin
         sdi[k] = (sh_sel[k] == PAD_FUNC_PERIPH) & pad_in[k];
      end
      rx     = (sh_sel[PAD_UART_RX] == PAD_FUNC_PERIPH) ? pad_in[PAD_UART_RX] : 1'b1;
      sda[0] = (sh_sel[PAD_I2C0_SDA] == PAD_FUNC_PERIPH) ? pad_in[PAD_I2C0_SDA] : 1'b1;
      scl[0] = (sh_sel[PAD_I2C0_SCL] == PAD_FUNC_PERIPH) ? pad_in[PAD_I2C0_SCL] : 1'b1;
      // SPI pads take I2C1 before the UART pads
      if (sh_sel[2] == PAD_FUNC_ALT) sda[1] = pad_in[2];
      else if (sh_sel[6] == PAD_FUNC_ALT) sda[1] = pad_in[6];
      else sda[1] = 1'b1;
      if (sh_sel[3] == PAD_FUNC_ALT) scl[1] = pad_in[3];
      else if (sh_sel[7] == PAD_FUNC_ALT) scl[1] = pad_in[7];
      else scl[1] = 1'b1;
      for (int k = 0; k < n_pads; k++) begin
         gin[k] = (sh_sel[k] == PAD_FUNC_GPIO) & pad_in[k];
      end
      return {sdi, rx, sda, scl, gin};
   endfunction

   function automatic wb_data_t shadow_word(wb_addr_t adr);
      wb_data_t w;
      w = '0;
      if (int'(adr) < n_pads) begin
         w[`PAD_FLD_SEL_LSB +: 2]           = sh_sel[adr];
         w[`PAD_FLD_DCFG_LSB +: `PAD_CFG_W] = sh_dcfg[adr];
         w[`PAD_FLD_GCFG_LSB +: `PAD_CFG_W] = sh_gcfg[adr];
      end
      return w;
   endfunction

   always_comb begin
      for (int k = 0; k < n_pads; k++) begin
         {exp_out[k], exp_oe[k]} = exp_drive(k);
         exp_cfg[k*`PAD_CFG_W +: `PAD_CFG_W] =
            (sh_sel[k] == PAD_FUNC_GPIO) ? sh_gcfg[k] : sh_dcfg[k];
         act_cfg[k*`PAD_CFG_W +: `PAD_CFG_W] = pad_cfg[k];
      end
      exp_rt = exp_route();
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic report_value(string what, logic [63:0] exp, logic [63:0] act);
      err_cnt++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
   endtask

   task automatic report_event(string what);
      err_cnt++;
      $display("%s: %s", cur_test, what);
   endtask

   drive_check: assert property (@(negedge clk) disable iff (!arst_n)
      {pad_out, pad_oe} === {exp_out, exp_oe})
      else report_value("pad drive", 64'({exp_out, exp_oe}), 64'({pad_out, pad_oe}));

   cfg_check: assert property (@(negedge clk) disable iff (!arst_n)
      act_cfg === exp_cfg)
      else report_value("pad config", 64'(exp_cfg), 64'(act_cfg));

   route_check: assert property (@(negedge clk) disable iff (!arst_n)
      {spi_sdi, uart_rx, i2c_sda_in, i2c_scl_in, gpio_in} === exp_rt)
      else report_value("routed inputs", 64'(exp_rt),
                        64'({spi_sdi, uart_rx, i2c_sda_in, i2c_scl_in, gpio_in}));

   ack_check: assert property (@(negedge clk) disable iff (!arst_n)
      (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
      else report_event("ack did not rise one cycle after the request");

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Called and returns 2 ns after a rising edge
   task automatic wb_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat);
      int unsigned waited;
      waited   = 0;
      rdat     = '0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      do begin
         @(posedge clk);
         #t_drive;
         waited++;
      end while (!wb_ack && waited < wb_wait_max);
      if (!wb_ack) begin
         $display("%s: no Wishbone ack after %0d cycles", cur_test, waited);
         $display("Test failed");
         $finish;
      end else begin
         rdat = wb_dat_r;
         if (we && int'(adr) < n_pads) begin
            sh_sel[adr]  = pad_func_e'(wdat[`PAD_FLD_SEL_LSB +: 2]);
            sh_dcfg[adr] = wdat[`PAD_FLD_DCFG_LSB +: `PAD_CFG_W];
            sh_gcfg[adr] = wdat[`PAD_FLD_GCFG_LSB +: `PAD_CFG_W];
         end
         // Strobe held through the edge that sees ack
         @(posedge clk);
         #t_drive;
         wb_cyc = 1'b0;
         wb_stb = 1'b0;
         wb_we  = 1'b0;
      end
   endtask

   task automatic wb_write(wb_addr_t adr, wb_data_t dat);
      wb_data_t rd_dummy;
      wb_cycle(1'b1, adr, dat, rd_dummy);
   endtask

   task automatic read_word(wb_addr_t adr);
      wb_data_t got;
      wb_data_t exp;
      exp = shadow_word(adr);
      wb_cycle(1'b0, adr, '0, got);
      read_check: assert (got === exp)
         else report_value($sformatf("read of word %0d", adr), 64'(exp), 64'(got));
   endtask

   task automatic set_pad(int k, pad_func_e f);
      wb_data_t d;
      d = lcg_next();
      d[`PAD_FLD_SEL_LSB +: 2] = f;
      wb_write(wb_addr_t'(k), d);
   endtask

   task automatic set_all_pads(pad_func_e f);
      for (int k = 0; k < n_pads; k++) begin
         set_pad(k, f);
      end
   endtask

   task automatic stir_inputs(int cycles);
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      for (int c = 0; c < cycles; c++) begin
         r0 = lcg_next();
         r1 = lcg_next();
         r2 = lcg_next();
         {spi_sck, spi_csn, spi_sdo, spi_oe, uart_tx, timer} = r0[31:17];
         {i2c_sda_out, i2c_sda_oe, i2c_scl_out, i2c_scl_oe} = r1[31:24];
         gpio_out = r1[23:14];
         gpio_dir = r2[31:22];
         pad_in   = r2[21:12];
         @(posedge clk);
         #t_drive;
      end
   endtask

   task automatic start_test(string name);
      cur_test     = name;
      err_at_start = err_cnt;
   endtask

   task automatic end_test();
      int n;
      n = err_cnt - err_at_start;
      test_cnt++;
      if (n != 0) bad_tests++;
      $display("test %-8s done, %0d error(s)", cur_test, n);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      lcg_state = lcg_seed;
      cur_test  = "reset";
      err_cnt   = 0;
      test_cnt  = 0;
      bad_tests = 0;
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
      {spi_sck, spi_csn, spi_sdo, spi_oe, uart_tx, timer} = '0;
      {i2c_sda_out, i2c_sda_oe, i2c_scl_out, i2c_scl_oe} = '0;
      {gpio_out, gpio_dir, pad_in} = '0;
      for (int k = 0; k < n_pads; k++) begin
         sh_sel[k]  = PAD_FUNC_PERIPH;
         sh_dcfg[k] = '0;
         sh_gcfg[k] = '0;
      end
      arst_n = 1'b0;
      repeat (4) @(posedge clk);
      #t_drive;
      arst_n = 1'b1;

      start_test("reset");
      stir_inputs(4);
      for (int a = 0; a < 16; a++) read_word(wb_addr_t'(a));
      end_test();

      start_test("regs");
      for (int a = 0; a < 16; a++) begin
         wb_write(wb_addr_t'(a), lcg_next());
         read_word(wb_addr_t'(a));
         stir_inputs(1);
      end
      for (int a = 0; a < 16; a++) read_word(wb_addr_t'(a));
      end_test();

      start_test("gpio");
      set_all_pads(PAD_FUNC_GPIO);
      stir_inputs(8);
      end_test();

      start_test("alt");
      set_all_pads(PAD_FUNC_ALT);
      stir_inputs(6);
      // I2C1 falls back to the UART pads
      set_pad(2, PAD_FUNC_PERIPH);
      set_pad(3, PAD_FUNC_PERIPH);
      stir_inputs(6);
      end_test();

      start_test("off");
      set_all_pads(PAD_FUNC_OFF);
      stir_inputs(6);
      end_test();

      $display("tests run %0d, tests with errors %0d, errors %0d", test_cnt, bad_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- compile.f
+incdir+.
pad_ctrl_pkg.sv
pad_lane_if.sv
pad_ctrl_regs.sv
pad_lane_mux.sv
pad_in_router.sv
pad_ctrl_top.sv
tb_pad_ctrl.sv

//--- Makefile
# Verilator build and run of the pad controller testbench

VERILATOR  ?= verilator
FILE_LIST  ?= compile.f
TB_TOP     ?= tb_pad_ctrl
RTL_TOP    ?= pad_ctrl_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test completed successfully
FAIL_MSG   ?= Test failed
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
